/* verilog/lspPkg.sv */
`default_nettype none

package lspPkg;

	typedef logic signed [15:0] lspWord;	// Q13 LSP value or table entry
	typedef logic [3:0] bufIndex;
	typedef logic [6:0] cb1Index;	// code0
	typedef logic [4:0] cb2Index;	// code1, code2

	localparam int lpcOrder = 10;
	localparam int splitOrder = 5;	// code1 below, code2 from here on

	localparam lspWord gapFirst = 16'sd10;
	localparam lspWord gapSecond = 16'sd5;

	// Clamp a widened result back to the 16-bit signed range
	function automatic lspWord satClamp(input logic signed [16:0] value);
		if (value > 17'sd32767)
			return 16'sh7fff;
		else if (value < -17'sd32768)
			return 16'sh8000;
		return value[15:0];
	endfunction

	function automatic lspWord satAdd(input lspWord a, input lspWord b);
		logic signed [16:0] wide;
		wide = a + b;
		return satClamp(wide);
	endfunction

	function automatic lspWord satSub(input lspWord a, input lspWord b);
		logic signed [16:0] wide;
		wide = a - b;
		return satClamp(wide);
	endfunction

endpackage

`default_nettype wire

/* verilog/codebookRom.sv */
`timescale 1ns/1ps
`default_nettype none

// Address layout is {table select, row, column}
module codebookRom (
	input wire clk,
	input wire [11:0] romAddr,
	output lspPkg::lspWord romData
);
	localparam int cb1Rows = 2 ** $bits(lspPkg::cb1Index);
	localparam int cb2Rows = 2 ** $bits(lspPkg::cb2Index);

	lspPkg::lspWord cb1Table [cb1Rows][lspPkg::lpcOrder];
	lspPkg::lspWord cb2Table [cb2Rows][lspPkg::lpcOrder];
	logic tableSel;
	lspPkg::cb1Index row;
	lspPkg::bufIndex col;

	assign tableSel = romAddr[11];
	assign row = romAddr[10:4];
	assign col = romAddr[3:0];

	// First stage rises by 2300 per column with a small row-dependent ripple
	for (genvar i = 0; i < cb1Rows; i++)
	begin : cb1Row
		for (genvar k = 0; k < lspPkg::lpcOrder; k++)
		begin : cb1Col
			assign cb1Table[i][k] =
				lspPkg::lspWord'((k + 1) * 2300 + (37 * i + 11 * k) % 512 - 256);
		end
	end

	// Second stage is a residual centred on zero
	for (genvar i = 0; i < cb2Rows; i++)
	begin : cb2Row
		for (genvar k = 0; k < lspPkg::lpcOrder; k++)
		begin : cb2Col
			assign cb2Table[i][k] = lspPkg::lspWord'((53 * i + 29 * k) % 1024 - 512);
		end
	end

	always_ff @(posedge clk)
	begin
		if (col >= lspPkg::lpcOrder)
			romData <= '0;	// Unused columns read as zero
		else if (tableSel)
			romData <= cb2Table[lspPkg::cb2Index'(row)][col];
		else
			romData <= cb1Table[row][col];
	end

endmodule

`default_nettype wire

/* verilog/lspBufferMem.sv */
`timescale 1ns/1ps
`default_nettype none

// Requester 0 has the highest priority, requester 3 the lowest
module lspBufferMem (
	input wire clk,
	input wire reset,
	input wire memReq0,
	input wire memWe0,
	input wire lspPkg::bufIndex memAddr0,
	input wire lspPkg::lspWord memWrData0,
	output logic memGrant0,
	input wire memReq1,
	input wire memWe1,
	input wire lspPkg::bufIndex memAddr1,
	input wire lspPkg::lspWord memWrData1,
	output logic memGrant1,
	input wire memReq2,
	input wire memWe2,
	input wire lspPkg::bufIndex memAddr2,
	input wire lspPkg::lspWord memWrData2,
	output logic memGrant2,
	input wire memReq3,
	input wire memWe3,
	input wire lspPkg::bufIndex memAddr3,
	input wire lspPkg::lspWord memWrData3,
	output logic memGrant3,
	output lspPkg::lspWord memRdData
);
	lspPkg::lspWord bufMem [lspPkg::lpcOrder];
	logic [3:0] reqVec, weVec, grantVec;
	lspPkg::bufIndex addrArr [4];
	lspPkg::lspWord dataArr [4];
	logic selWe;
	lspPkg::bufIndex selAddr;
	lspPkg::lspWord selData;
	logic addrOk;

	assign reqVec = {memReq3, memReq2, memReq1, memReq0};
	assign weVec = {memWe3, memWe2, memWe1, memWe0};
	assign addrArr = '{memAddr0, memAddr1, memAddr2, memAddr3};
	assign dataArr = '{memWrData0, memWrData1, memWrData2, memWrData3};

	////////////////////////////////////////////////////////////
	// Fixed-priority grant

	always_comb
	begin
		grantVec = '0;
		selWe = 1'b0;
		selAddr = '0;
		selData = '0;
		for (int i = 3; i >= 0; i--)	// Walk downwards so the lowest index wins
		begin
			if (reqVec[i])
			begin
				grantVec = '0;
				grantVec[i] = 1'b1;
				selWe = weVec[i];
				selAddr = addrArr[i];
				selData = dataArr[i];
			end
		end
	end

	assign {memGrant3, memGrant2, memGrant1, memGrant0} = grantVec;
	assign addrOk = (selAddr < lspPkg::lpcOrder);

	////////////////////////////////////////////////////////////
	// Granted access

	always_ff @(posedge clk)
	begin
		if (|grantVec && selWe && addrOk)
			bufMem[selAddr] <= selData;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			memRdData <= '0;
		else if (|grantVec && !selWe)
			memRdData <= addrOk ? bufMem[selAddr] : '0;	// One cycle read
	end

endmodule

`default_nettype wire

/* verilog/codebookSum.sv */
`timescale 1ns/1ps
`default_nettype none

module codebookSum (
	input wire clk,
	input wire reset,
	input wire go,
	input wire lspPkg::cb1Index code0,
	input wire lspPkg::cb2Index code1,
	input wire lspPkg::cb2Index code2,
	output logic [11:0] romAddr,
	input wire lspPkg::lspWord romData,
	output logic memReq,
	output logic memWe,
	output lspPkg::bufIndex memAddr,
	output lspPkg::lspWord memWrData,
	input wire memGrant,
	output logic fin
);
	typedef enum logic [1:0] {sumIdle, fetchFirst, fetchSecond, writeWord} sumState;

	localparam lspPkg::bufIndex lastWord = lspPkg::bufIndex'(lspPkg::lpcOrder - 1);

	sumState state;
	lspPkg::bufIndex j;
	lspPkg::lspWord firstEntry;
	lspPkg::cb2Index secondRow;

	assign secondRow = (j < lspPkg::splitOrder) ? code1 : code2;

	// Second stage address stays up while writing so romData holds across a stall
	assign romAddr = (state == fetchFirst) ? {1'b0, code0, j} : {1'b1, 2'b00, secondRow, j};

	assign memReq = (state == writeWord);
	assign memWe = memReq;
	assign memAddr = j;
	assign memWrData = lspPkg::satAdd(firstEntry, romData);
	assign fin = memReq && memGrant && (j == lastWord);	// Lands 30 cycles after go

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= sumIdle;
			j <= '0;
		end
		else
		begin
			case (state)
				sumIdle:
					if (go)
					begin
						j <= '0;
						state <= fetchFirst;
					end
				fetchFirst:
					state <= fetchSecond;
				fetchSecond:
					state <= writeWord;
				writeWord:
					if (memGrant)
					begin
						j <= j + 1'b1;
						state <= (j == lastWord) ? sumIdle : fetchFirst;
					end
				default:
					state <= sumIdle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == fetchSecond)
			firstEntry <= romData;	// First stage entry of word j
	end

endmodule

`default_nettype wire

/* verilog/lspExpand.sv */
`timescale 1ns/1ps
`default_nettype none

module lspExpand (
	input wire clk,
	input wire reset,
	input wire go,
	input wire lspPkg::lspWord gap,
	output logic memReq,
	output logic memWe,
	output lspPkg::bufIndex memAddr,
	output lspPkg::lspWord memWrData,
	input wire memGrant,
	input wire lspPkg::lspWord memRdData,
	output logic fin
);
	typedef enum logic [2:0] {
		expIdle, readFirst, loadFirst, readCur, calcStep, writePrev, writeCur
	} expState;

	localparam lspPkg::bufIndex lastWord = lspPkg::bufIndex'(lspPkg::lpcOrder - 1);

	expState state;
	lspPkg::bufIndex j;
	lspPkg::lspWord prevWord;	// buf[j-1] as last written
	lspPkg::lspWord curWord;
	lspPkg::lspWord delta;
	lspPkg::lspWord deltaCalc;
	lspPkg::lspWord nextPrev;
	logic stepEnd;

	// Half of (buf[j-1] - buf[j] + gap), memRdData holds buf[j] in calcStep
	assign deltaCalc = lspPkg::satAdd(lspPkg::satSub(prevWord, memRdData), gap) >>> 1;

	assign stepEnd = (state == calcStep && deltaCalc <= 0) || (state == writeCur && memGrant);
	assign nextPrev = (state == calcStep) ? memRdData : memWrData;

	assign memReq = state inside {readFirst, readCur, writePrev, writeCur};
	assign memWe = state inside {writePrev, writeCur};

	always_comb
	begin
		memAddr = j;
		memWrData = lspPkg::satAdd(curWord, delta);
		if (state == readFirst)
			memAddr = '0;
		else if (state == writePrev)
		begin
			memAddr = j - 1'b1;
			memWrData = lspPkg::satSub(prevWord, delta);
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= expIdle;
			j <= '0;
			fin <= 1'b0;
		end
		else
		begin
			fin <= 1'b0;
			case (state)
				expIdle:
					if (go)
					begin
						j <= lspPkg::bufIndex'(1);
						state <= readFirst;
					end
				readFirst:
					if (memGrant)
						state <= loadFirst;
				loadFirst:
					state <= readCur;
				readCur:
					if (memGrant)
						state <= calcStep;
				calcStep:
					if (deltaCalc > 0)
						state <= writePrev;	// Too close, push both apart
				writePrev:
					if (memGrant)
						state <= writeCur;
				default: ;
			endcase
			if (stepEnd)
			begin
				if (j == lastWord)
				begin
					fin <= 1'b1;
					state <= expIdle;
				end
				else
				begin
					j <= j + 1'b1;
					state <= readCur;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == loadFirst)
			prevWord <= memRdData;
		else if (stepEnd)
			prevWord <= nextPrev;
		if (state == calcStep)
		begin
			curWord <= memRdData;
			delta <= deltaCalc;
		end
	end

endmodule

`default_nettype wire

/* verilog/lspStability.sv */
`timescale 1ns/1ps
`default_nettype none

module lspStability #(
	parameter lspPkg::lspWord lowLimit = 16'sd40,
	parameter lspPkg::lspWord minSpacing = 16'sd321,
	parameter lspPkg::lspWord highLimit = 16'sd25681
) (
	input wire clk,
	input wire reset,
	input wire go,
	output logic memReq,
	output logic memWe,
	output lspPkg::bufIndex memAddr,
	output lspPkg::lspWord memWrData,
	input wire memGrant,
	input wire lspPkg::lspWord memRdData,
	output logic fin
);
	typedef enum logic [2:0] {
		stbIdle, readA, readB, compare, writeA, writeB, spaceRead, spaceWrite
	} stbState;

	// Also the last pass index, there are as many passes as pairs
	localparam lspPkg::bufIndex lastPair = lspPkg::bufIndex'(lspPkg::lpcOrder - 2);
	localparam lspPkg::bufIndex lastWord = lspPkg::bufIndex'(lspPkg::lpcOrder - 1);

	stbState state;
	lspPkg::bufIndex j;
	lspPkg::bufIndex pass;
	lspPkg::lspWord wordA, wordB, prevWord;
	lspPkg::lspWord spacedRaw, spaced;
	logic pairEnd;

	assign pairEnd = (state == compare && wordA <= memRdData) || (state == writeB && memGrant);

	// Floor at j = 0 falls out of the spacing rule with a virtual lowLimit - minSpacing below
	assign spacedRaw = (lspPkg::satSub(memRdData, prevWord) < minSpacing) ?
		lspPkg::satAdd(prevWord, minSpacing) : memRdData;
	assign spaced = (j == lastWord && spacedRaw > highLimit) ? highLimit : spacedRaw;

	assign memReq = state inside {readA, readB, writeA, writeB, spaceRead, spaceWrite};
	assign memWe = state inside {writeA, writeB, spaceWrite};

	always_comb
	begin
		memAddr = j;
		memWrData = spaced;
		if (state == readB || state == writeB)
			memAddr = j + 1'b1;
		if (state == writeA)
			memWrData = wordB;	// Swapped pair
		else if (state == writeB)
			memWrData = wordA;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= stbIdle;
			j <= '0;
			pass <= '0;
			fin <= 1'b0;
		end
		else
		begin
			fin <= 1'b0;
			case (state)
				stbIdle:
					if (go)
					begin
						j <= '0;
						pass <= '0;
						state <= readA;
					end
				readA:
					if (memGrant)
						state <= readB;
				readB:
					if (memGrant)
						state <= compare;
				compare:
					if (wordA > memRdData)
						state <= writeA;
				writeA:
					if (memGrant)
						state <= writeB;
				spaceRead:
					if (memGrant)
						state <= spaceWrite;
				spaceWrite:
					if (memGrant)
					begin
						if (j == lastWord)
						begin
							fin <= 1'b1;
							state <= stbIdle;
						end
						else
						begin
							j <= j + 1'b1;
							state <= spaceRead;
						end
					end
				default: ;
			endcase

			////////////////////////////////////////////////////////////
			// Bubble sort pair and pass stepping

			if (pairEnd)
			begin
				if (j != lastPair)
				begin
					j <= j + 1'b1;
					state <= readA;
				end
				else if (pass != lastPair)
				begin
					j <= '0;
					pass <= pass + 1'b1;
					state <= readA;
				end
				else
				begin
					j <= '0;
					state <= spaceRead;	// Sorted, on to the spacing pass
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == readB && memGrant)
			wordA <= memRdData;
		if (state == compare)
			wordB <= memRdData;
		if (state == stbIdle)
			prevWord <= lspPkg::satSub(lowLimit, minSpacing);
		else if (state == spaceWrite && memGrant)
			prevWord <= spaced;
	end

endmodule

`default_nettype wire

/* verilog/lspQuantSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module lspQuantSequencer (
	input wire clk,
	input wire reset,
	input wire start,
	input wire lspPkg::cb1Index code0,
	input wire lspPkg::cb2Index code1,
	input wire lspPkg::cb2Index code2,
	output lspPkg::cb1Index codeHold0,
	output lspPkg::cb2Index codeHold1,
	output lspPkg::cb2Index codeHold2,
	output logic sumGo,
	output logic expandGo,
	output logic stabilityGo,
	output lspPkg::lspWord gap,
	input wire sumFin,
	input wire expandFin,
	input wire stabilityFin,
	output logic busy,
	output logic done
);
	typedef enum logic [2:0] {idle, sum, expandFirst, expandSecond, stability} seqState;

	seqState state;

	assign busy = (state != idle);
	assign gap = (state == expandSecond) ? lspPkg::gapSecond : lspPkg::gapFirst;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= idle;
			sumGo <= 1'b0;
			expandGo <= 1'b0;
			stabilityGo <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			sumGo <= 1'b0;
			expandGo <= 1'b0;
			stabilityGo <= 1'b0;
			done <= 1'b0;
			case (state)
				idle:
					if (start)
					begin
						state <= sum;
						sumGo <= 1'b1;
					end
				sum:
					if (sumFin)
					begin
						state <= expandFirst;
						expandGo <= 1'b1;
					end
				expandFirst:
					if (expandFin)
					begin
						state <= expandSecond;	// Same engine again, smaller gap
						expandGo <= 1'b1;
					end
				expandSecond:
					if (expandFin)
					begin
						state <= stability;
						stabilityGo <= 1'b1;
					end
				stability:
					if (stabilityFin)
					begin
						state <= idle;
						done <= 1'b1;	// Same cycle busy drops
					end
				default:
					state <= idle;
			endcase
		end
	end

	// Codes only taken in while idle
	always_ff @(posedge clk)
	begin
		if (state == idle && start)
		begin
			codeHold0 <= code0;
			codeHold1 <= code1;
			codeHold2 <= code2;
		end
	end

endmodule

`default_nettype wire

/* verilog/lspGetQuant.sv */
`timescale 1ns/1ps
`default_nettype none

module lspGetQuant #(
	parameter lspPkg::lspWord lowLimit = 16'sd40,
	parameter lspPkg::lspWord minSpacing = 16'sd321,
	parameter lspPkg::lspWord highLimit = 16'sd25681
) (
	input wire clk,
	input wire reset,
	input wire start,
	input wire lspPkg::cb1Index code0,
	input wire lspPkg::cb2Index code1,
	input wire lspPkg::cb2Index code2,
	input wire lspPkg::bufIndex rdAddr,
	output lspPkg::lspWord rdData,
	output logic busy,
	output logic done
);
	lspPkg::cb1Index codeHold0;
	lspPkg::cb2Index codeHold1, codeHold2;
	logic sumGo, expandGo, stabilityGo;
	logic sumFin, expandFin, stabilityFin;
	lspPkg::lspWord gap;
	logic [11:0] romAddr;
	lspPkg::lspWord romData;
	lspPkg::lspWord memRdData;

	logic sumReq, sumWe, sumGrant;
	lspPkg::bufIndex sumAddr;
	lspPkg::lspWord sumWrData;
	logic expandReq, expandWe, expandGrant;
	lspPkg::bufIndex expandAddr;
	lspPkg::lspWord expandWrData;
	logic stabilityReq, stabilityWe, stabilityGrant;
	lspPkg::bufIndex stabilityAddr;
	lspPkg::lspWord stabilityWrData;

	assign rdData = memRdData;

	////////////////////////////////////////////////////////////
	// Control

	lspQuantSequencer sequencer (
		.clk(clk), .reset(reset), .start(start),
		.code0(code0), .code1(code1), .code2(code2),
		.codeHold0(codeHold0), .codeHold1(codeHold1), .codeHold2(codeHold2),
		.sumGo(sumGo), .expandGo(expandGo), .stabilityGo(stabilityGo), .gap(gap),
		.sumFin(sumFin), .expandFin(expandFin), .stabilityFin(stabilityFin),
		.busy(busy), .done(done)
	);

	////////////////////////////////////////////////////////////
	// Engines

	codebookRom rom (.clk(clk), .romAddr(romAddr), .romData(romData));

	codebookSum sumEngine (
		.clk(clk), .reset(reset), .go(sumGo),
		.code0(codeHold0), .code1(codeHold1), .code2(codeHold2),
		.romAddr(romAddr), .romData(romData),
		.memReq(sumReq), .memWe(sumWe), .memAddr(sumAddr), .memWrData(sumWrData),
		.memGrant(sumGrant), .fin(sumFin)
	);

	lspExpand expandEngine (
		.clk(clk), .reset(reset), .go(expandGo), .gap(gap),
		.memReq(expandReq), .memWe(expandWe), .memAddr(expandAddr),
		.memWrData(expandWrData), .memGrant(expandGrant), .memRdData(memRdData),
		.fin(expandFin)
	);

	lspStability #(
		.lowLimit(lowLimit), .minSpacing(minSpacing), .highLimit(highLimit)
	) stabilityEngine (
		.clk(clk), .reset(reset), .go(stabilityGo),
		.memReq(stabilityReq), .memWe(stabilityWe), .memAddr(stabilityAddr),
		.memWrData(stabilityWrData), .memGrant(stabilityGrant), .memRdData(memRdData),
		.fin(stabilityFin)
	);

	////////////////////////////////////////////////////////////
	// Shared buffer, external read is the lowest requester

	lspBufferMem bufferMem (
		.clk(clk), .reset(reset),
		.memReq0(sumReq), .memWe0(sumWe), .memAddr0(sumAddr),
		.memWrData0(sumWrData), .memGrant0(sumGrant),
		.memReq1(expandReq), .memWe1(expandWe), .memAddr1(expandAddr),
		.memWrData1(expandWrData), .memGrant1(expandGrant),
		.memReq2(stabilityReq), .memWe2(stabilityWe), .memAddr2(stabilityAddr),
		.memWrData2(stabilityWrData), .memGrant2(stabilityGrant),
		.memReq3(!busy), .memWe3(1'b0), .memAddr3(rdAddr),
		.memWrData3(16'sd0), .memGrant3(),	// Never contended while idle
		.memRdData(memRdData)
	);

endmodule

`default_nettype wire

/* sim/lspGetQuantTb.sv */
`timescale 1ns/1ps
`default_nettype none

module lspGetQuantTb;

	// Tighter than the defaults so the floor, spacing and ceiling all act on these tables
	localparam int lowLimit = 2000;
	localparam int minSpacing = 2000;
	localparam int highLimit = 23000;
	localparam int randomRuns = 200;
	localparam int cycleLimit = 220 * 800 + 2000;	// Worst run well under 800 cycles

	logic clk = 1'b0;
	logic reset;
	logic start;
	lspPkg::cb1Index code0;
	lspPkg::cb2Index code1;
	lspPkg::cb2Index code2;
	lspPkg::bufIndex rdAddr;
	lspPkg::lspWord rdData;
	logic busy;
	logic done;

	int model [10];
	int readBack [10];
	int errorCount = 0;
	int checkCount = 0;
	int testCount = 0;
	int doneCount = 0;
	int cycleCount = 0;
	int seedInit;

	lspGetQuant #(
		.lowLimit(lspPkg::lspWord'(lowLimit)),
		.minSpacing(lspPkg::lspWord'(minSpacing)),
		.highLimit(lspPkg::lspWord'(highLimit))
	) dut (
		.clk(clk), .reset(reset), .start(start),
		.code0(code0), .code1(code1), .code2(code2),
		.rdAddr(rdAddr), .rdData(rdData), .busy(busy), .done(done)
	);

	always #50 clk = ~clk;

	always @(negedge clk)
	begin
		if (done)
			doneCount++;
	end

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("timeout: no done seen before the cycle limit of %0d", cycleLimit);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Reference model

	function automatic int sat16(input int v);
		if (v > 32767)
			return 32767;
		if (v < -32768)
			return -32768;
		return v;
	endfunction

	function automatic int firstStage(input int i, input int j);
		return (j + 1) * 2300 + ((37 * i + 11 * j) % 512) - 256;
	endfunction

	function automatic int secondStage(input int i, input int j);
		return ((53 * i + 29 * j) % 1024) - 512;
	endfunction

	task automatic expandModel(input int g);
		int d;
		for (int j = 1; j < 10; j++)
		begin
			d = sat16(sat16(model[j - 1] - model[j]) + g) >>> 1;
			if (d > 0)
			begin
				model[j - 1] = sat16(model[j - 1] - d);
				model[j] = sat16(model[j] + d);
			end
		end
	endtask

	task automatic computeModel(input int c0, input int c1, input int c2);
		int t;
		for (int j = 0; j < 10; j++)
			model[j] = sat16(firstStage(c0, j) + secondStage((j < 5) ? c1 : c2, j));
		expandModel(10);
		expandModel(5);
		for (int p = 0; p < 9; p++)
		begin
			for (int j = 0; j < 9; j++)
			begin
				if (model[j] > model[j + 1])
				begin
					t = model[j];
					model[j] = model[j + 1];
					model[j + 1] = t;
				end
			end
		end
		if (model[0] < lowLimit)
			model[0] = lowLimit;	// Floor
		for (int j = 0; j < 9; j++)
		begin
			if (sat16(model[j + 1] - model[j]) < minSpacing)
				model[j + 1] = sat16(model[j] + minSpacing);
		end
		if (model[9] > highLimit)
			model[9] = highLimit;	// Ceiling
	endtask

	////////////////////////////////////////////////////////////
	// Checks and bus tasks

	task automatic checkValue(input string name, input logic [15:0] got,
			input logic [15:0] expected);
		checkCount++;
		if (got !== expected)
		begin
			errorCount++;
			$display("mismatch %s: got %h, expected %h", name, got, expected);
		end
	endtask

	task automatic waitDone();
		@(negedge clk);
		while (done !== 1'b1)
			@(negedge clk);
	endtask

	task automatic readWords();
		for (int a = 0; a < 10; a++)
		begin
			@(posedge clk);
			rdAddr <= lspPkg::bufIndex'(a);
			@(posedge clk);	// Address taken here
			@(negedge clk);
			readBack[a] = int'(rdData);
		end
	endtask

	task automatic checkOrder();
		for (int j = 1; j < 10; j++)
		begin
			if (readBack[j] < readBack[j - 1])
			begin
				errorCount++;
				$display("words %0d and %0d are out of order", j - 1, j);
			end
			else if (!(j == 9 && readBack[j] == highLimit)
					&& readBack[j] - readBack[j - 1] < minSpacing)
			begin
				errorCount++;
				$display("word %0d is closer than the minimum spacing to word %0d", j, j - 1);
			end
		end
	endtask

	task automatic runTest(input string label, input int c0, input int c1, input int c2,
			input bit extraStart);
		int errorsBefore;
		int donesBefore;
		errorsBefore = errorCount;
		testCount++;
		computeModel(c0, c1, c2);
		donesBefore = doneCount;
		@(posedge clk);
		start <= 1'b1;
		code0 <= lspPkg::cb1Index'(c0);
		code1 <= lspPkg::cb2Index'(c1);
		code2 <= lspPkg::cb2Index'(c2);
		@(posedge clk);
		start <= 1'b0;
		if (extraStart)
		begin
			repeat (40) @(posedge clk);
			start <= 1'b1;	// Other codes, must be ignored
			code0 <= lspPkg::cb1Index'(c0 + 45);
			code1 <= lspPkg::cb2Index'(c1 + 9);
			code2 <= lspPkg::cb2Index'(c2 + 17);
			@(posedge clk);
			start <= 1'b0;
		end
		waitDone();
		readWords();
		for (int j = 0; j < 10; j++)
			checkValue($sformatf("rdData[%0d]", j), 16'(readBack[j]), 16'(model[j]));
		checkOrder();
		repeat (5) @(posedge clk);
		@(negedge clk);
		checkValue("done pulse count", 16'(doneCount - donesBefore), 16'd1);
		checkValue("busy", 16'(busy), 16'd0);
		$display("test %0d %s codes %h %h %h: %s", testCount, label, c0, c1, c2,
			(errorCount == errorsBefore) ? "ok" : "errors");
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence

	initial
	begin
		reset = 1'b1;
		start = 1'b0;
		code0 = '0;
		code1 = '0;
		code2 = '0;
		rdAddr = '0;
		seedInit = $urandom(32'hbc47_976f);
		repeat (8) @(posedge clk);
		reset <= 1'b0;

		// Idle after reset
		testCount++;
		for (int i = 0; i < 12; i++)
		begin
			@(negedge clk);
			checkValue("busy", 16'(busy), 16'd0);
			checkValue("done", 16'(done), 16'd0);
		end
		$display("test %0d idle after reset: %s", testCount, (errorCount == 0) ? "ok" : "errors");

		runTest("edge", 0, 0, 0, 1'b0);
		runTest("edge", 127, 31, 31, 1'b0);
		runTest("edge", 0, 31, 0, 1'b0);
		runTest("edge", 0, 0, 31, 1'b0);
		runTest("edge", 127, 0, 31, 1'b0);
		runTest("edge", 127, 31, 0, 1'b0);
		runTest("start while busy", 64, 7, 22, 1'b1);

		for (int i = 0; i < randomRuns; i++)
			runTest("random", $urandom % 128, $urandom % 32, $urandom % 32, 1'b0);

		$display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
		if (errorCount == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
verilog/lspPkg.sv
verilog/codebookRom.sv
verilog/lspBufferMem.sv
verilog/codebookSum.sv
verilog/lspExpand.sv
verilog/lspStability.sv
verilog/lspQuantSequencer.sv
verilog/lspGetQuant.sv
sim/lspGetQuantTb.sv

/* Makefile */
TOOL = verilator
FLAGS = --binary --timing -Wno-fatal
TOP = lspGetQuantTb
FILELIST = list.f

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf obj_dir
